// File: verilog/noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

////////////////////////////////////////
// Mesh geometry
////////////////////////////////////////

`define NOC_DIMX        4                           // Tiles along x
`define NOC_DIMY        4                           // Tiles along y
`define NOC_X_W         $clog2(`NOC_DIMX)           // x coordinate width
`define NOC_Y_W         $clog2(`NOC_DIMY)           // y coordinate width
`define NOC_ID_W        (`NOC_X_W + `NOC_Y_W)       // Tile id, x in the low bits

// Output ports of a mesh switch: N, E, W, S and local
`define NOC_NUM_PORTS   5

////////////////////////////////////////
// Flit format
////////////////////////////////////////

`define NOC_FLIT_W      64
`define NOC_DST_LSB     0                           // Destination tile id field
`define NOC_DST_MSB     (`NOC_DST_LSB + `NOC_ID_W - 1)

`endif

// File: verilog/noc_flit_pkg.sv
`default_nettype none

`include "noc_macros.svh"

package noc_flit_pkg;

    ////////////////////////////////////////
    // Flit and its type tag
    ////////////////////////////////////////

    typedef logic [`NOC_FLIT_W-1:0] flit_t;             // Whole flit, payload and header fields

    // Type travels beside the flit, not inside it
    typedef enum logic [1:0] {
        flit_header      = 2'd0,                        // First flit, carries the route
        flit_body        = 2'd1,
        flit_tail        = 2'd2,                        // Last flit, releases the VC
        flit_header_tail = 2'd3                         // Single-flit packet
    } flit_type_e;

    // Tile id, low bits x and high bits y
    typedef logic [`NOC_ID_W-1:0] tile_id_t;

endpackage

`default_nettype wire

// File: verilog/noc_port_pkg.sv
`default_nettype none

`include "noc_macros.svh"

package noc_port_pkg;

    // Output ports of the switch, value doubles as vector index
    typedef enum logic [2:0] {
        port_north = 3'd0,
        port_east  = 3'd1,
        port_west  = 3'd2,
        port_south = 3'd3,
        port_local = 3'd4                               // Ejection to the tile
    } port_e;

    // One bit per output port, indexed by port_e
    typedef logic [`NOC_NUM_PORTS-1:0] port_vec_t;

    // Single port to one-hot vector
    function automatic port_vec_t port_onehot(input port_e p);
        port_vec_t v;
        v    = '0;
        v[p] = 1'b1;
        return v;
    endfunction

endpackage

`default_nettype wire

// File: verilog/xy_route_calc.sv
`default_nettype none

`include "noc_macros.svh"

module xy_route_calc #(
    parameter noc_flit_pkg::tile_id_t TILE_ID = '0      // Coordinate of this switch
) (
    input  noc_flit_pkg::flit_t flit,
    output noc_port_pkg::port_e out_port
);
    import noc_flit_pkg::*;
    import noc_port_pkg::*;

    tile_id_t             dst;                          // Destination tile of the flit
    logic [`NOC_X_W-1:0]  x_cur;
    logic [`NOC_Y_W-1:0]  y_cur;
    logic [`NOC_X_W-1:0]  x_dst;
    logic [`NOC_Y_W-1:0]  y_dst;

    ////////////////////////////////////////
    // Coordinate split
    ////////////////////////////////////////

    assign dst   = flit[`NOC_DST_MSB:`NOC_DST_LSB];

    // x sits in the low bits, y right above it
    assign x_cur = TILE_ID[`NOC_X_W-1:0];
    assign y_cur = TILE_ID[`NOC_X_W +: `NOC_Y_W];
    assign x_dst = dst[`NOC_X_W-1:0];
    assign y_dst = dst[`NOC_X_W +: `NOC_Y_W];

    ////////////////////////////////////////
    // Dimension-ordered routing
    ////////////////////////////////////////

    // X is resolved first, then Y, so no turn from Y back into X
    always_comb begin
        if (x_dst > x_cur) begin
            out_port = port_east;                       // Further along x
        end else if (x_dst < x_cur) begin
            out_port = port_west;
        end else if (y_dst < y_cur) begin
            out_port = port_north;                      // Row 0 is the north edge
        end else if (y_dst > y_cur) begin
            out_port = port_south;
        end else begin
            out_port = port_local;                      // Arrived, eject
        end
    end

endmodule

`default_nettype wire

// File: verilog/flit_stage.sv
`default_nettype none

module flit_stage (
    input  logic                     clk,
    input  logic                     rst_p,
    // Input buffer side
    input  logic                     req,               // One-cycle strobe, flit valid
    input  noc_flit_pkg::flit_t      flit,
    input  noc_flit_pkg::flit_type_e flit_type,
    input  logic                     granted,           // Any SA grant this cycle
    output logic                     avail,
    // Toward the tracker
    output logic                     load,              // Flit taken at this edge
    output logic                     full,
    // Held flit
    output noc_flit_pkg::flit_t      flit_out,
    output noc_flit_pkg::flit_type_e flit_type_out,
    output logic                     tail_flit
);
    import noc_flit_pkg::*;

    logic       full_q;                                 // Stage holds a flit
    flit_t      flit_q;
    flit_type_e type_q;

    ////////////////////////////////////////
    // Handshake with the buffer
    ////////////////////////////////////////

    // Free now, or freeing at this edge, so a new flit may follow directly
    assign avail = ~full_q | granted;
    assign load  = req & avail;
    assign full  = full_q;

    always_ff @(posedge clk) begin
        if (rst_p) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;                             // Also covers leave-and-refill
        end else if (granted) begin
            full_q <= 1'b0;                             // Flit left through the switch
        end
    end

    // Flit and type only move on an accepted request
    always_ff @(posedge clk) begin
        if (load) begin
            flit_q <= flit;
            type_q <= flit_type;
        end
    end

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////

    assign flit_out      = flit_q;
    assign flit_type_out = type_q;

    // Tail marks the end of the packet, only meaningful while full
    assign tail_flit = full_q & ((type_q == flit_tail) | (type_q == flit_header_tail));

endmodule

`default_nettype wire

// File: verilog/vc_port_tracker.sv
`default_nettype none

module vc_port_tracker (
    input  logic                     clk,
    input  logic                     rst_p,
    // From the stage
    input  logic                     load,              // Flit taken at this edge
    input  noc_flit_pkg::flit_type_e flit_type,         // Type of the incoming flit
    input  noc_port_pkg::port_e      new_port,          // Route of the incoming flit
    input  logic                     full,
    input  logic                     tail_flit,         // Held flit ends the packet
    // Allocators
    input  noc_port_pkg::port_vec_t  va_gnt,
    input  noc_port_pkg::port_vec_t  sa_gnt,
    output noc_port_pkg::port_vec_t  va_req,
    output noc_port_pkg::port_vec_t  sa_req
);
    import noc_flit_pkg::*;
    import noc_port_pkg::*;

    logic      is_header;                               // Incoming flit opens a packet
    logic      hdr_load;
    port_e     cur_port;                                // Route of the packet in flight
    port_vec_t cur_vec;
    port_vec_t new_vec;
    port_vec_t va_pend;                                 // Waiting for a VC on that port
    port_vec_t vc_assigned;                             // VC held on that port
    port_vec_t va_won;
    port_vec_t release_vec;

    ////////////////////////////////////////
    // Header capture
    ////////////////////////////////////////

    assign is_header = (flit_type == flit_header) | (flit_type == flit_header_tail);
    assign hdr_load  = load & is_header;

    assign new_vec = port_onehot(new_port);
    assign cur_vec = port_onehot(cur_port);

    // Body and tail flits reuse the stored route
    always_ff @(posedge clk) begin
        if (rst_p) begin
            cur_port <= port_local;
        end else if (hdr_load) begin
            cur_port <= new_port;
        end
    end

    ////////////////////////////////////////
    // VC allocation
    ////////////////////////////////////////

    // Request drops in the grant cycle itself
    assign va_req = va_pend & ~va_gnt;
    assign va_won = va_pend & va_gnt;                   // Grants on ports we asked for

    always_ff @(posedge clk) begin
        if (rst_p) begin
            va_pend <= '0;
        end else begin
            va_pend <= va_req | (hdr_load ? new_vec : '0);  // Request rises next cycle
        end
    end

    ////////////////////////////////////////
    // Switch allocation
    ////////////////////////////////////////

    // Only the stored route may ask for the switch, and only with a flit present
    assign sa_req = full ? (vc_assigned & cur_vec) : '0;

    // Tail winning the switch gives the VC back at the same edge
    assign release_vec = (full & tail_flit) ? (sa_gnt & vc_assigned) : '0;

    always_ff @(posedge clk) begin
        if (rst_p) begin
            vc_assigned <= '0;
        end else begin
            vc_assigned <= (vc_assigned | va_won) & ~release_vec;
        end
    end

endmodule

`default_nettype wire

// File: verilog/routing_vc.sv
`default_nettype none

module routing_vc #(
    parameter noc_flit_pkg::tile_id_t TILE_ID = '0      // Coordinate of this switch
) (
    input  logic                     clk,
    input  logic                     rst_p,
    // Input buffer side
    input  logic                     req,
    input  noc_flit_pkg::flit_t      flit,
    input  noc_flit_pkg::flit_type_e flit_type,
    output logic                     avail,
    // VC allocator
    output noc_port_pkg::port_vec_t  va_req,
    input  noc_port_pkg::port_vec_t  va_gnt,
    // Switch allocator
    output noc_port_pkg::port_vec_t  sa_req,
    input  noc_port_pkg::port_vec_t  sa_gnt,
    // Toward the crossbar
    output noc_flit_pkg::flit_t      flit_out,
    output noc_flit_pkg::flit_type_e flit_type_out,
    output logic                     tail_flit
);
    import noc_port_pkg::*;

    logic  granted;                                     // Held flit wins the switch
    logic  load;
    logic  full;
    port_e route_port;                                  // XY result for the incoming flit

    // One route per packet, so at most one grant bit is set
    assign granted = |sa_gnt;

    ////////////////////////////////////////
    // One-entry stage
    ////////////////////////////////////////

    flit_stage u_stage (
        .clk           (clk),
        .rst_p         (rst_p),
        .req           (req),
        .flit          (flit),
        .flit_type     (flit_type),
        .granted       (granted),
        .avail         (avail),
        .load          (load),
        .full          (full),
        .flit_out      (flit_out),
        .flit_type_out (flit_type_out),
        .tail_flit     (tail_flit)
    );

    ////////////////////////////////////////
    // Route and allocator requests
    ////////////////////////////////////////

    // Routed straight off the input, result latched by the tracker
    xy_route_calc #(
        .TILE_ID (TILE_ID)
    ) u_route (
        .flit     (flit),
        .out_port (route_port)
    );

    vc_port_tracker u_track (
        .clk       (clk),
        .rst_p     (rst_p),
        .load      (load),
        .flit_type (flit_type),
        .new_port  (route_port),
        .full      (full),
        .tail_flit (tail_flit),
        .va_gnt    (va_gnt),
        .sa_gnt    (sa_gnt),
        .va_req    (va_req),
        .sa_req    (sa_req)
    );

endmodule

`default_nettype wire

// File: bench/routing_vc_tb.sv
`default_nettype none

`include "noc_macros.svh"

module routing_vc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import noc_flit_pkg::*;
    import noc_port_pkg::*;

    localparam logic [`NOC_X_W-1:0] TILE_X = 1;
    localparam logic [`NOC_Y_W-1:0] TILE_Y = 2;
    localparam tile_id_t  TILE_ID      = {TILE_Y, TILE_X};   // y above x
    localparam int        RESET_CYCLES = 3;
    localparam int        RAND_EXTRA   = 3;                  // Extra grant delay 0..2
    localparam bit [31:0] SEED         = 32'h75dafa6d;
    localparam string     VEC_FILE     = "bench/routing_vc_vectors.txt";

    logic       clk       = 1'b0;
    logic       rst_p     = 1'b1;
    logic       req       = 1'b0;
    flit_t      flit      = '0;
    flit_type_e flit_type = flit_header;
    port_vec_t  va_gnt    = '0;
    port_vec_t  sa_gnt    = '0;
    logic       avail;
    port_vec_t  va_req;
    port_vec_t  sa_req;
    flit_t      flit_out;
    flit_type_e flit_type_out;
    logic       tail_flit;

    // Vector columns
    int v_dst[$];
    int v_len[$];
    int v_va[$];
    int v_sa[$];
    int v_port[$];

    // Expected traffic, in flight order
    flit_t      exp_flit_q[$];
    flit_type_e exp_type_q[$];
    port_e      exp_port_q[$];
    port_e      exp_va_file[$];                         // VA port from the file
    port_e      exp_va_xy[$];                           // VA port from the local XY model

    int        error_count = 0;
    int        wd_cycles   = 0;
    int        va_base     = 0;                         // Per packet grant delays
    int        sa_base     = 0;
    int        va_cnt      = 0;
    int        va_tgt      = 0;
    int        sa_cnt      = 0;
    int        sa_tgt      = 0;
    port_vec_t va_s        = '0;                        // Outputs sampled at the falling edge
    port_vec_t sa_s        = '0;
    port_vec_t vc_model    = '0;                        // Ports whose VA grant was seen
    flit_t     held_flit   = '0;
    bit        held        = 1'b0;

    routing_vc #(
        .TILE_ID (TILE_ID)
    ) UUT (
        .clk           (clk),
        .rst_p         (rst_p),
        .req           (req),
        .flit          (flit),
        .flit_type     (flit_type),
        .avail         (avail),
        .va_req        (va_req),
        .va_gnt        (va_gnt),
        .sa_req        (sa_req),
        .sa_gnt        (sa_gnt),
        .flit_out      (flit_out),
        .flit_type_out (flit_type_out),
        .tail_flit     (tail_flit)
    );

    always #50 clk = ~clk;                              // 100 ns period

    ////////////////////////////////////////
    // Reference helpers and compare tasks
    ////////////////////////////////////////

    // Dimension-ordered route from this tile, x first
    function automatic port_e xy_expect(input int dst);
        logic [`NOC_X_W-1:0] dx;
        logic [`NOC_Y_W-1:0] dy;
        dx = dst[`NOC_X_W-1:0];
        dy = dst[`NOC_X_W +: `NOC_Y_W];
        if (dx > TILE_X) return port_east;
        if (dx < TILE_X) return port_west;
        if (dy < TILE_Y) return port_north;
        if (dy > TILE_Y) return port_south;
        return port_local;
    endfunction

    function automatic port_vec_t one_hot(input port_e p);
        return port_vec_t'(1) << int'(p);
    endfunction

    function automatic port_e vec_to_port(input port_vec_t v);
        port_e p;
        p = port_local;
        for (int i = 0; i < `NOC_NUM_PORTS; i++) begin
            if (v[i]) p = port_e'(i);
        end
        return p;
    endfunction

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("FAIL at %0d ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "Check failed");
    endtask

    task automatic check_port(input port_e got, input port_e exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %s, expected %s", what, got.name(), exp.name()));
    endtask

    task automatic check_flit(input flit_t got, input flit_t exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_type(input flit_type_e got, input flit_type_e exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %s, expected %s", what, got.name(), exp.name()));
    endtask

    task automatic check_vec(input port_vec_t got, input port_vec_t exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
    endtask

    ////////////////////////////////////////
    // Vector file and buffer driver
    ////////////////////////////////////////

    task automatic read_vectors();
        int    fd;
        int    n;
        int    d, l, a, s, p;
        string line;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VEC_FILE);
            $display("TESTBENCH FAILED");
            $fatal(1, "Vector file missing");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line[0] != 8'h23) begin     // Skip # lines
                    n = $sscanf(line, "%h %d %d %d %d", d, l, a, s, p);
                    if (n == 5) begin
                        v_dst.push_back(d);
                        v_len.push_back(l);
                        v_va.push_back(a);
                        v_sa.push_back(s);
                        v_port.push_back(p);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Wait for room, then strobe req for one cycle
    task automatic send_flit(input flit_t f, input flit_type_e t, input port_e p,
                             input int va_dly, input int sa_dly);
        @(negedge clk);
        while (!avail) @(negedge clk);
        @(posedge clk);
        if (t == flit_header || t == flit_header_tail) begin
            va_base = va_dly;
            sa_base = sa_dly;
        end
        req       <= 1'b1;
        flit      <= f;
        flit_type <= t;
        exp_flit_q.push_back(f);
        exp_type_q.push_back(t);
        exp_port_q.push_back(p);
        @(posedge clk);
        req <= 1'b0;
    endtask

    ////////////////////////////////////////
    // Allocator model
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (rst_p) begin
            va_gnt <= '0;
            sa_gnt <= '0;
            va_cnt = 0;
            sa_cnt = 0;
        end else begin
            va_gnt <= '0;
            sa_gnt <= '0;
            if (va_s != 0) begin
                if (va_cnt == 0) va_tgt = va_base + ($urandom % RAND_EXTRA);
                if (va_cnt >= va_tgt) begin
                    va_gnt <= va_s;                     // Grant exactly what was asked
                    va_cnt = 0;
                end else begin
                    va_cnt++;
                end
            end
            // Request stays up in its own grant cycle and is not granted twice
            if (sa_s != 0 && sa_gnt == 0) begin
                if (sa_cnt == 0) sa_tgt = sa_base + ($urandom % RAND_EXTRA);
                if (sa_cnt >= sa_tgt) begin
                    sa_gnt <= sa_s;
                    sa_cnt = 0;
                end else begin
                    sa_cnt++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst_p) begin
            // VA request rise, hold and drop
            if (va_s == 0 && va_req != 0) begin
                if ($countones(va_req) != 1)
                    report_mismatch($sformatf("va_req not one-hot: %b", va_req));
                if (exp_va_file.size() == 0)
                    report_mismatch("va_req rose with no header pending");
                check_port(vec_to_port(va_req), exp_va_file.pop_front(), "VA port vs file");
                check_port(vec_to_port(va_req), exp_va_xy.pop_front(), "VA port vs XY rule");
            end else if (va_s != 0 && va_gnt == 0) begin
                check_vec(va_req, va_s, "va_req held until grant");
            end else if (va_gnt != 0) begin
                check_vec(va_req, '0, "va_req in grant cycle");
            end

            // No switch request without a VC
            check_vec(sa_req & ~vc_model, '0, "sa_req before VA grant");
            if (sa_req != 0 && exp_port_q.size() != 0)
                check_vec(sa_req, one_hot(exp_port_q[0]), "sa_req port");

            if (sa_gnt != 0) begin
                if (exp_flit_q.size() == 0)
                    report_mismatch("SA grant with no flit expected");
                check_port(vec_to_port(sa_gnt), exp_port_q[0], "SA grant port");
                check_flit(flit_out, exp_flit_q[0], "flit_out order");
                check_type(flit_type_out, exp_type_q[0], "flit_type_out");
                check_bit(tail_flit, exp_type_q[0] == flit_tail ||
                          exp_type_q[0] == flit_header_tail, "tail_flit");
                if (tail_flit) vc_model &= ~sa_gnt;     // VC released at this edge
                void'(exp_flit_q.pop_front());
                void'(exp_type_q.pop_front());
                void'(exp_port_q.pop_front());
                held = 1'b0;
            end else if (sa_req != 0) begin
                check_bit(avail, 1'b0, "avail under held-back SA grant");
                if (held) check_flit(flit_out, held_flit, "flit_out stable while held");
                held      = 1'b1;
                held_flit = flit_out;
            end

            vc_model |= va_gnt & va_s;                  // Assigned from the next cycle
        end
        va_s = va_req;
        sa_s = sa_req;
    end

    ////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Timeout: the DUT stopped making progress after %0d cycles", wd_cycles);
        $display("TESTBENCH FAILED");
        $fatal(1, "Timeout");
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int         total_flits;
        int         max_dly;
        flit_t      f;
        flit_type_e t;
        port_e      p;

        void'($urandom(SEED));
        read_vectors();
        if (v_dst.size() == 0) begin
            $display("The vector file holds no usable lines");
            $display("TESTBENCH FAILED");
            $fatal(1, "No vectors");
        end

        total_flits = 0;
        max_dly     = 0;
        foreach (v_len[i]) begin
            total_flits += v_len[i];
            if (v_va[i] + v_sa[i] > max_dly) max_dly = v_va[i] + v_sa[i];
        end
        max_dly  += 2 * (RAND_EXTRA - 1);
        wd_cycles = total_flits * (max_dly + 4) + 4 * v_dst.size() + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_p <= 1'b0;
        @(negedge clk);
        check_vec(va_req, '0, "va_req after reset");
        check_vec(sa_req, '0, "sa_req after reset");
        check_bit(avail, 1'b1, "avail after reset");
        check_bit(tail_flit, 1'b0, "tail_flit after reset");

        foreach (v_dst[pk]) begin
            p = port_e'(v_port[pk]);
            exp_va_file.push_back(p);
            exp_va_xy.push_back(xy_expect(v_dst[pk]));
            for (int fi = 0; fi < v_len[pk]; fi++) begin
                if (v_len[pk] == 1) t = flit_header_tail;
                else if (fi == 0) t = flit_header;
                else if (fi == v_len[pk] - 1) t = flit_tail;
                else t = flit_body;
                // Packet and flit index above, destination in the low field
                f = {16'hC0DE, 16'(pk), 16'(fi), 12'h000, 4'(v_dst[pk])};
                send_flit(f, t, p, v_va[pk], v_sa[pk]);
            end
        end

        while (exp_flit_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        check_vec(va_req, '0, "va_req at end");
        check_vec(sa_req, '0, "sa_req at end");
        check_bit(avail, 1'b1, "avail at end");

        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/routing_vc_vectors.txt
# dst(hex tile id, y high x low)  length  va_delay  sa_delay  port(0 N,1 E,2 W,3 S,4 L)
# switch sits at x 1, y 2 (tile 9)
a 3 0 0 1
8 2 1 0 2
1 4 0 1 0
d 1 0 0 3
9 3 2 2 4
3 1 0 0 1
0 2 3 1 2
5 3 1 3 0
9 1 0 0 4
e 4 2 0 1
c 2 0 2 2
d 3 4 1 3
6 1 1 1 1
4 3 0 0 2
1 1 2 0 0
9 2 1 4 4
f 3 0 1 1
d 2 2 2 3
7 1 5 0 1
8 4 0 3 2
5 1 0 0 0
b 2 3 0 1
9 4 0 2 4
2 3 1 1 1
c 1 2 5 2
1 2 0 0 0
d 4 1 0 3
a 1 0 3 1
0 3 4 0 2
9 1 1 1 4
6 2 0 4 1
5 4 3 2 0
e 1 0 1 1
4 2 2 0 2
d 1 5 5 3
3 3 0 0 1
8 1 1 2 2
1 3 2 1 0
9 2 0 0 4
b 4 1 1 1
c 3 0 0 2
d 2 3 0 3

// File: compile.f
+incdir+verilog
verilog/noc_flit_pkg.sv
verilog/noc_port_pkg.sv
verilog/xy_route_calc.sv
verilog/flit_stage.sv
verilog/vc_port_tracker.sv
verilog/routing_vc.sv
bench/routing_vc_tb.sv

// File: Makefile
# Verilator flow for the routing stage

VERILATOR  ?= verilator
FILELIST   ?= compile.f
TB_TOP     ?= routing_vc_tb
RTL_TOP    ?= routing_vc
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary -j 0
FAIL_MSG   ?= TESTBENCH FAILED
PASS_MSG   ?= TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(shell grep -v '^+' $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
